//--- dv/tb_exu.sv
// one op in flight except the stray pulses of test 6; fixed LFSR seed, 32-bit word rules
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu;

  localparam int XLEN       = `EXU_XLEN;
  localparam int DIV_LAT    = `EXU_DIV_STEPS + 3;
  localparam int RST_CYCLES = 16;
  localparam int N_BASIC    = 160;
  localparam int N_SHIFT    = 120;
  localparam int N_MUL      = 120;
  localparam int N_DIV      = 120;
  localparam int N_CORNER   = 16;
  localparam int N_STRAY    = 4;
  localparam int N_TOTAL    = N_BASIC + N_SHIFT + N_MUL + N_DIV + N_CORNER + N_STRAY;
  localparam int TIMEOUT_CYCLES = 2 * N_TOTAL * DIV_LAT + RST_CYCLES;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

  logic             i_clk;
  logic             i_rst_n;
  logic             i_valid;
  exu_pkg::alu_op_e i_op;
  logic             i_word;
  logic [XLEN-1:0]  i_src_a;
  logic [XLEN-1:0]  i_src_b;
  logic             o_busy;
  logic             o_valid;
  logic [XLEN-1:0]  o_result;

  logic [31:0] lfsr = 32'd99259;
  int          err_count = 0;
  int          pass_count = 0;
  int          test_err_start = 0;
  int          valid_count = 0;
  int          cycle_count = 0;

  exu exu_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_word   (i_word),
    .i_src_a  (i_src_a),
    .i_src_b  (i_src_b),
    .o_busy   (o_busy),
    .o_valid  (o_valid),
    .o_result (o_result)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(negedge i_clk) begin
    if (o_valid) begin
      valid_count <= valid_count + 1;
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("run stopped: no finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // galois LFSR stepped once per bit taken
  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      r = {r[XLEN-2:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic is_div_op(input exu_pkg::alu_op_e op);
    return (op == exu_pkg::ALU_DIV) || (op == exu_pkg::ALU_DIVU) ||
           (op == exu_pkg::ALU_REM) || (op == exu_pkg::ALU_REMU);
  endfunction

  function automatic exu_pkg::alu_op_e pick_op(input int grp, input logic [2:0] idx);
    exu_pkg::alu_op_e op;
    case (grp)
      1: begin
        case (idx)
          3'd0:    op = exu_pkg::ALU_ADD;
          3'd1:    op = exu_pkg::ALU_SUB;
          3'd2:    op = exu_pkg::ALU_SLT;
          3'd3:    op = exu_pkg::ALU_SLTU;
          3'd4:    op = exu_pkg::ALU_XOR;
          3'd5:    op = exu_pkg::ALU_AND;
          3'd6:    op = exu_pkg::ALU_OR;
          default: op = exu_pkg::ALU_COPY;
        endcase
      end
      2: op = (idx[1:0] == 2'd0) ? exu_pkg::ALU_SLL :
              (idx[1:0] == 2'd1) ? exu_pkg::ALU_SRL : exu_pkg::ALU_SRA;
      3: op = (idx[1:0] == 2'd0) ? exu_pkg::ALU_MUL :
              (idx[1:0] == 2'd1) ? exu_pkg::ALU_MULH :
              (idx[1:0] == 2'd2) ? exu_pkg::ALU_MULHSU : exu_pkg::ALU_MULHU;
      default: op = (idx[1:0] == 2'd0) ? exu_pkg::ALU_DIV :
                    (idx[1:0] == 2'd1) ? exu_pkg::ALU_DIVU :
                    (idx[1:0] == 2'd2) ? exu_pkg::ALU_REM : exu_pkg::ALU_REMU;
    endcase
    return op;
  endfunction

  // expected result from the RV64IM rules
  function automatic logic [XLEN-1:0] model(input exu_pkg::alu_op_e op, input logic word,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [XLEN-1:0]          res;
    logic [XLEN-1:0]          da;
    logic [XLEN-1:0]          db;
    logic signed [XLEN-1:0]   sa;
    logic signed [XLEN-1:0]   sb;
    logic signed [2*XLEN-1:0] wa;
    logic signed [2*XLEN-1:0] wb;
    logic [2*XLEN-1:0]        prod;
    logic                     sgn;
    logic                     min_neg;
    int                       sh;
    sgn = (op == exu_pkg::ALU_DIV) || (op == exu_pkg::ALU_REM);
    sh  = word ? b[4:0] : b[5:0];
    da  = a;
    db  = b;
    if (word) begin
      da = {{(XLEN-32){sgn & a[31]}}, a[31:0]};
      db = {{(XLEN-32){sgn & b[31]}}, b[31:0]};
    end
    min_neg = word ? (da[31:0] == 32'h8000_0000) : (da == {1'b1, {(XLEN-1){1'b0}}});
    sa = a;
    sb = b;
    // signed sources widen with their sign
    wa = sa;
    wb = sb;
    case (op)
      exu_pkg::ALU_ADD:  res = a + b;
      exu_pkg::ALU_SUB:  res = a - b;
      exu_pkg::ALU_SLT:  res = (sa < sb) ? 1 : 0;
      exu_pkg::ALU_SLTU: res = (a < b) ? 1 : 0;
      exu_pkg::ALU_XOR:  res = a ^ b;
      exu_pkg::ALU_AND:  res = a & b;
      exu_pkg::ALU_OR:   res = a | b;
      exu_pkg::ALU_COPY: res = b;
      exu_pkg::ALU_SLL:  res = a << sh;
      exu_pkg::ALU_SRL:  res = word ? (a[31:0] >> sh) : (a >> sh);
      exu_pkg::ALU_SRA: begin
        if (word) begin
          res = $signed(a[31:0]) >>> sh;
        end else begin
          res = sa >>> sh;
        end
      end
      exu_pkg::ALU_MUL:  res = a * b;
      exu_pkg::ALU_MULH: begin
        prod = wa * wb;
        res  = prod[2*XLEN-1:XLEN];
      end
      exu_pkg::ALU_MULHSU: begin
        wb   = b;
        prod = wa * wb;
        res  = prod[2*XLEN-1:XLEN];
      end
      exu_pkg::ALU_MULHU: begin
        prod = a * b;
        res  = prod[2*XLEN-1:XLEN];
      end
      default: begin
        sa = da;
        sb = db;
        if (db == '0) begin
          res = (op == exu_pkg::ALU_DIV || op == exu_pkg::ALU_DIVU) ? '1 : da;
        end else if (sgn && (sb == -1) && min_neg) begin
          res = (op == exu_pkg::ALU_DIV) ? da : '0;
        end else if (op == exu_pkg::ALU_DIV) begin
          res = sa / sb;
        end else if (op == exu_pkg::ALU_REM) begin
          res = sa % sb;
        end else begin
          res = (op == exu_pkg::ALU_DIVU) ? (da / db) : (da % db);
        end
      end
    endcase
    if (word) begin
      res = {{(XLEN-32){res[31]}}, res[31:0]};
    end
    return res;
  endfunction

  task automatic compare(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] got);
    if (got !== exp) begin
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
      err_count++;
    end else begin
      pass_count++;
    end
  endtask

  // issue one op and wait for its result valid; stray pulses go out while busy
  task automatic run_op(input exu_pkg::alu_op_e op, input logic word,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input bit stray);
    logic [XLEN-1:0] exp_res;
    int              exp_lat;
    int              cycles;
    exp_res = model(op, word, a, b);
    exp_lat = is_div_op(op) ? DIV_LAT : 1;
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_op    <= op;
    i_word  <= word;
    i_src_a <= a;
    i_src_b <= b;
    @(posedge i_clk);
    i_valid <= 1'b0;
    cycles = 1;
    @(negedge i_clk);
    while (o_valid !== 1'b1) begin
      compare("o_busy", 1'b1, o_busy);
      @(posedge i_clk);
      if (stray && (cycles % 8 == 0) && (cycles < 48)) begin
        i_valid <= 1'b1;
        i_op    <= pick_op(1 + cycles / 16, rand_bits(3));
        i_word  <= rand_bits(1);
        i_src_a <= rand_bits(XLEN);
        i_src_b <= rand_bits(XLEN);
      end else begin
        i_valid <= 1'b0;
      end
      @(negedge i_clk);
      cycles++;
    end
    if (cycles != exp_lat) begin
      $display("ERROR t=%0t o_valid latency expected %0d got %0d", $time, exp_lat, cycles);
      err_count++;
    end
    compare("o_busy", 1'b0, o_busy);
    compare("o_result", exp_res, o_result);
  endtask

  task automatic end_test(input int num, input string name, input int ops);
    $display("test %0d %s: %0d ops, %0d errors", num, name, ops, err_count - test_err_start);
    test_err_start = err_count;
  endtask

  initial begin
    exu_pkg::alu_op_e op;
    logic             word;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  r;
    int               snap;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_op    = exu_pkg::ALU_ADD;
    i_word  = 1'b0;
    i_src_a = '0;
    i_src_b = '0;
    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    compare("o_valid", 1'b0, o_valid);
    compare("o_busy", 1'b0, o_busy);

    for (int i = 0; i < N_BASIC; i++) begin
      op   = pick_op(1, rand_bits(3));
      word = rand_bits(1);
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN);
      run_op(op, word, a, b, 1'b0);
    end
    end_test(1, "add/sub/compare/logic/copy", N_BASIC);

    for (int i = 0; i < N_SHIFT; i++) begin
      op   = pick_op(2, rand_bits(2));
      word = rand_bits(1);
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN);
      run_op(op, word, a, b, 1'b0);
    end
    end_test(2, "shifts", N_SHIFT);

    for (int i = 0; i < N_MUL; i++) begin
      op   = pick_op(3, rand_bits(2));
      word = rand_bits(1);
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN);
      // walk all top-bit combinations
      a[XLEN-1] = i[0];
      b[XLEN-1] = i[1];
      run_op(op, word, a, b, 1'b0);
    end
    end_test(3, "multiplies", N_MUL);

    for (int i = 0; i < N_DIV; i++) begin
      op   = pick_op(4, rand_bits(2));
      word = rand_bits(1);
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN);
      r    = rand_bits(5);
      b    = b >> r;
      run_op(op, word, a, b, 1'b0);
    end
    end_test(4, "divides", N_DIV);

    for (int k = 0; k < N_CORNER; k++) begin
      op   = pick_op(4, k[1:0]);
      word = k[2];
      r    = rand_bits(32);
      if (!k[3]) begin
        // upper word of b is junk in word mode
        a = rand_bits(XLEN);
        b = word ? {r[31:0], 32'b0} : '0;
      end else begin
        a = word ? {r[31:0], 32'h8000_0000} : {1'b1, {(XLEN-1){1'b0}}};
        b = word ? {~r[31:0], 32'hffff_ffff} : '1;
      end
      run_op(op, word, a, b, 1'b0);
    end
    end_test(5, "zero divisor and overflow", N_CORNER);

    for (int i = 0; i < N_STRAY; i++) begin
      op   = pick_op(4, i[1:0]);
      word = i[0];
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN) >> 20;
      @(posedge i_clk);
      snap = valid_count;
      run_op(op, word, a, b, 1'b1);
      repeat (10) @(negedge i_clk);
      @(posedge i_clk);
      if (valid_count - snap != 1) begin
        $display("ERROR t=%0t o_valid count expected 1 got %0d", $time, valid_count - snap);
        err_count++;
      end
    end
    end_test(6, "ignored valid while busy", N_STRAY);

    $display("summary: %0d checks passed, %0d errors", pass_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/key_mux.sv
rtl/alu.sv
rtl/div_fsm.sv
rtl/div_counter.sv
rtl/div_datapath.sv
rtl/exu.sv
dv/tb_exu.sv

//--- rtl/alu.sv
// one-cycle result registered on i_load; divide and unknown op codes give zero
`timescale 1ns/1ps
`include "exu_params.svh"

module alu (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_load,
  input  exu_pkg::alu_op_e     i_op,
  input  logic                 i_word,
  input  logic [`EXU_XLEN-1:0] i_src_a,
  input  logic [`EXU_XLEN-1:0] i_src_b,
  output logic [`EXU_XLEN-1:0] o_result
);

  localparam int XLEN    = `EXU_XLEN;
  localparam int SH_W    = $clog2(XLEN);
  localparam int KEY_LEN = $bits(exu_pkg::alu_op_e);
  localparam int NR_OPS  = 15;

  logic [XLEN-1:0]   add_res;
  logic [XLEN:0]     sub_ext;
  logic              signed_lt;
  logic              unsigned_lt;
  logic [SH_W-1:0]   shamt;
  logic [XLEN-1:0]   srl_src;
  logic [XLEN-1:0]   sra_src;
  logic [XLEN-1:0]   sll_res;
  logic [XLEN-1:0]   srl_res;
  logic [XLEN-1:0]   sra_res;
  logic [2*XLEN-1:0] prod_ss;
  logic [2*XLEN-1:0] prod_su;
  logic [2*XLEN-1:0] prod_uu;
  logic [XLEN-1:0]   sel_res;
  logic [XLEN-1:0]   word_res;

  logic [NR_OPS*(KEY_LEN+XLEN)-1:0] lut;

  assign add_res = i_src_a + i_src_b;

  // borrow of the unsigned subtract drives both compares
  assign sub_ext     = {1'b0, i_src_a} - {1'b0, i_src_b};
  assign unsigned_lt = sub_ext[XLEN];
  assign signed_lt   = (i_src_a[XLEN-1] ^ i_src_b[XLEN-1]) ? i_src_a[XLEN-1] : sub_ext[XLEN];

  // word shifts use five amount bits and only the low word of a
  assign shamt   = i_word ? {1'b0, i_src_b[SH_W-2:0]} : i_src_b[SH_W-1:0];
  assign srl_src = i_word ? {{(XLEN-32){1'b0}}, i_src_a[31:0]} : i_src_a;
  assign sra_src = i_word ? {{(XLEN-32){i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign sll_res = i_src_a << shamt;
  assign srl_res = srl_src >> shamt;
  assign sra_res = $signed(sra_src) >>> shamt;

  // full-width products, high halves for mulh variants
  assign prod_ss = {{XLEN{i_src_a[XLEN-1]}}, i_src_a} * {{XLEN{i_src_b[XLEN-1]}}, i_src_b};
  assign prod_su = {{XLEN{i_src_a[XLEN-1]}}, i_src_a} * {{XLEN{1'b0}}, i_src_b};
  assign prod_uu = {{XLEN{1'b0}}, i_src_a} * {{XLEN{1'b0}}, i_src_b};

  assign lut = {
    exu_pkg::ALU_COPY,   i_src_b,
    exu_pkg::ALU_ADD,    add_res,
    exu_pkg::ALU_SUB,    sub_ext[XLEN-1:0],
    exu_pkg::ALU_SLT,    {{(XLEN-1){1'b0}}, signed_lt},
    exu_pkg::ALU_SLTU,   {{(XLEN-1){1'b0}}, unsigned_lt},
    exu_pkg::ALU_XOR,    i_src_a ^ i_src_b,
    exu_pkg::ALU_AND,    i_src_a & i_src_b,
    exu_pkg::ALU_OR,     i_src_a | i_src_b,
    exu_pkg::ALU_SLL,    sll_res,
    exu_pkg::ALU_SRL,    srl_res,
    exu_pkg::ALU_SRA,    sra_res,
    exu_pkg::ALU_MUL,    prod_uu[XLEN-1:0],
    exu_pkg::ALU_MULH,   prod_ss[2*XLEN-1:XLEN],
    exu_pkg::ALU_MULHSU, prod_su[2*XLEN-1:XLEN],
    exu_pkg::ALU_MULHU,  prod_uu[2*XLEN-1:XLEN]
  };

  key_mux #(
    .NR_KEY   (NR_OPS),
    .KEY_LEN  (KEY_LEN),
    .DATA_LEN (XLEN)
  ) key_mux_inst (
    .i_key  (i_op),
    .i_lut  (lut),
    .o_data (sel_res)
  );

  assign word_res = i_word ? {{(XLEN-32){sel_res[31]}}, sel_res[31:0]} : sel_res;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_result <= '0;
    end else if (i_load) begin
      o_result <= word_res;
    end
  end

endmodule

//--- rtl/div_counter.sv
// counts enabled cycles from zero; o_last marks step EXU_DIV_STEPS, a power of two
`timescale 1ns/1ps
`include "exu_params.svh"

module div_counter (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_clear,
  input  logic i_en,
  output logic o_last
);

  localparam int CNT_W = $clog2(`EXU_DIV_STEPS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`EXU_DIV_STEPS - 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else if (i_clear) begin
      count <= '0;
    end else if (i_en) begin
      count <= count + 1'b1;
    end
  end

  assign o_last = (count == LAST_CNT);

endmodule

//--- rtl/div_datapath.sv
// operands are sampled on i_load only; o_result is valid the cycle after i_finish
`timescale 1ns/1ps
`include "exu_params.svh"

module div_datapath (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_load,
  input  logic                 i_step,
  input  logic                 i_finish,
  input  exu_pkg::alu_op_e     i_op,
  input  logic                 i_word,
  input  logic [`EXU_XLEN-1:0] i_src_a,
  input  logic [`EXU_XLEN-1:0] i_src_b,
  output logic [`EXU_XLEN-1:0] o_result
);

  localparam int XLEN = `EXU_XLEN;

  logic            is_signed;
  logic [XLEN-1:0] a_cond;
  logic [XLEN-1:0] b_cond;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] min_val;

  logic [XLEN-1:0] divisor_r;
  logic [XLEN-1:0] dividend_r;
  logic [XLEN-1:0] part_rem;
  logic [XLEN-1:0] quot;
  logic            op_rem;
  logic            op_word;
  logic            neg_quot;
  logic            neg_rem;
  logic            div_zero;
  logic            div_ovf;

  logic [XLEN:0]   shifted;
  logic [XLEN+1:0] trial;
  logic [XLEN-1:0] q_out;
  logic [XLEN-1:0] r_out;
  logic [XLEN-1:0] res;

  assign is_signed = (i_op == exu_pkg::ALU_DIV) || (i_op == exu_pkg::ALU_REM);

  // word ops take the low word, extended by the op's signedness
  assign a_cond  = i_word ? {{(XLEN-32){is_signed & i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign b_cond  = i_word ? {{(XLEN-32){is_signed & i_src_b[31]}}, i_src_b[31:0]} : i_src_b;
  assign a_neg   = is_signed & a_cond[XLEN-1];
  assign b_neg   = is_signed & b_cond[XLEN-1];
  assign min_val = i_word ? {{(XLEN-31){1'b1}}, 31'b0} : {1'b1, {(XLEN-1){1'b0}}};

  assign shifted = {part_rem, quot[XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b0, divisor_r};

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      divisor_r  <= b_neg ? -b_cond : b_cond;
      dividend_r <= a_cond;
      part_rem   <= '0;
      quot       <= a_neg ? -a_cond : a_cond;
      op_rem     <= (i_op == exu_pkg::ALU_REM) || (i_op == exu_pkg::ALU_REMU);
      op_word    <= i_word;
      neg_quot   <= a_neg ^ b_neg;
      neg_rem    <= a_neg;
      div_zero   <= (b_cond == '0);
      div_ovf    <= is_signed && (a_cond == min_val) && (b_cond == '1);
    end else if (i_step) begin
      // restore by keeping the shifted value when the trial goes negative
      if (!trial[XLEN+1]) begin
        part_rem <= trial[XLEN-1:0];
        quot     <= {quot[XLEN-2:0], 1'b1};
      end else begin
        part_rem <= shifted[XLEN-1:0];
        quot     <= {quot[XLEN-2:0], 1'b0};
      end
    end
  end

  always_comb begin
    if (div_zero) begin
      q_out = '1;
      r_out = dividend_r;
    end else if (div_ovf) begin
      q_out = dividend_r;
      r_out = '0;
    end else begin
      q_out = neg_quot ? -quot : quot;
      r_out = neg_rem ? -part_rem : part_rem;
    end
  end

  assign res = op_rem ? r_out : q_out;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_result <= '0;
    end else if (i_finish) begin
      o_result <= op_word ? {{(XLEN-32){res[31]}}, res[31:0]} : res;
    end
  end

endmodule

//--- rtl/div_fsm.sv
// accepts an op only when idle; i_valid during a divide is dropped and no result valid is held
`timescale 1ns/1ps

module div_fsm (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  exu_pkg::alu_op_e i_op,
  input  logic             i_last,
  output logic             o_alu_load,
  output logic             o_div_load,
  output logic             o_div_step,
  output logic             o_div_finish,
  output logic             o_busy,
  output logic             o_valid,
  output logic             o_sel_div
);

  exu_pkg::div_state_e state;
  exu_pkg::div_state_e state_nxt;
  logic                is_div;
  logic                accept;

  always_comb begin
    case (i_op)
      exu_pkg::ALU_DIV, exu_pkg::ALU_DIVU, exu_pkg::ALU_REM, exu_pkg::ALU_REMU: is_div = 1'b1;
      default: is_div = 1'b0;
    endcase
  end

  assign accept       = i_valid && (state == exu_pkg::DIV_IDLE);
  assign o_alu_load   = accept && !is_div;
  assign o_div_load   = accept && is_div;
  assign o_div_step   = (state == exu_pkg::DIV_RUN);
  assign o_div_finish = (state == exu_pkg::DIV_FINISH);
  assign o_busy       = (state != exu_pkg::DIV_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      exu_pkg::DIV_IDLE:   if (o_div_load) state_nxt = exu_pkg::DIV_LOAD;
      exu_pkg::DIV_LOAD:   state_nxt = exu_pkg::DIV_RUN;
      exu_pkg::DIV_RUN:    if (i_last) state_nxt = exu_pkg::DIV_FINISH;
      exu_pkg::DIV_FINISH: state_nxt = exu_pkg::DIV_IDLE;
      default:             state_nxt = exu_pkg::DIV_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= exu_pkg::DIV_IDLE;
      o_valid   <= 1'b0;
      o_sel_div <= 1'b0;
    end else begin
      state   <= state_nxt;
      o_valid <= o_alu_load || o_div_finish;
      // select follows the last accepted op
      if (accept) begin
        o_sel_div <= is_div;
      end
    end
  end

endmodule

//--- rtl/exu.sv
// no back-pressure; o_result holds until the next accepted op, divides take 67 cycles
`timescale 1ns/1ps
`include "exu_params.svh"

module exu (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  exu_pkg::alu_op_e     i_op,
  input  logic                 i_word,
  input  logic [`EXU_XLEN-1:0] i_src_a,
  input  logic [`EXU_XLEN-1:0] i_src_b,
  output logic                 o_busy,
  output logic                 o_valid,
  output logic [`EXU_XLEN-1:0] o_result
);

  logic                 alu_load;
  logic                 div_load;
  logic                 div_step;
  logic                 div_finish;
  logic                 div_last;
  logic                 sel_div;
  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] div_result;

  div_fsm div_fsm_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_last       (div_last),
    .o_alu_load   (alu_load),
    .o_div_load   (div_load),
    .o_div_step   (div_step),
    .o_div_finish (div_finish),
    .o_busy       (o_busy),
    .o_valid      (o_valid),
    .o_sel_div    (sel_div)
  );

  div_counter div_counter_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (div_load),
    .i_en    (div_step),
    .o_last  (div_last)
  );

  alu alu_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_load   (alu_load),
    .i_op     (i_op),
    .i_word   (i_word),
    .i_src_a  (i_src_a),
    .i_src_b  (i_src_b),
    .o_result (alu_result)
  );

  div_datapath div_datapath_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_load   (div_load),
    .i_step   (div_step),
    .i_finish (div_finish),
    .i_op     (i_op),
    .i_word   (i_word),
    .i_src_a  (i_src_a),
    .i_src_b  (i_src_b),
    .o_result (div_result)
  );

  assign o_result = sel_div ? div_result : alu_result;

endmodule

//--- rtl/exu_params.svh
// data width and divider iteration count; the divider needs EXU_DIV_STEPS equal to EXU_XLEN
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// integer register width
`define EXU_XLEN 64

// one quotient bit per iteration
`define EXU_DIV_STEPS 64

`endif

//--- rtl/exu_pkg.sv
// op codes follow the core's decoder encoding; codes outside the list are not decoded
package exu_pkg;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'b00000,
    ALU_SUB    = 5'b00001,
    ALU_SLT    = 5'b00010,
    ALU_SLTU   = 5'b00011,
    ALU_XOR    = 5'b00100,
    ALU_AND    = 5'b00101,
    ALU_OR     = 5'b00110,
    ALU_SLL    = 5'b00111,
    ALU_SRL    = 5'b01000,
    ALU_SRA    = 5'b01001,
    ALU_MUL    = 5'b01010,
    ALU_DIV    = 5'b01011,
    ALU_DIVU   = 5'b01100,
    ALU_REM    = 5'b01101,
    ALU_REMU   = 5'b01110,
    ALU_COPY   = 5'b01111,
    ALU_MULH   = 5'b11001,
    ALU_MULHSU = 5'b11010,
    ALU_MULHU  = 5'b11011
  } alu_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE   = 2'b00,
    DIV_LOAD   = 2'b01,
    DIV_RUN    = 2'b10,
    DIV_FINISH = 2'b11
  } div_state_e;

endpackage

//--- rtl/key_mux.sv
// lookup mux; the first pair sits in the top bits of i_lut and a key with no match gives zero
`timescale 1ns/1ps

module key_mux #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   i_key,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut,
  output logic [DATA_LEN-1:0]                  o_data
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  logic [KEY_LEN-1:0]  pair_key  [NR_KEY];
  logic [DATA_LEN-1:0] pair_data [NR_KEY];

  // split the flat table, pair 0 taken from the msb end
  always_comb begin
    for (int i = 0; i < NR_KEY; i++) begin
      pair_key[i]  = i_lut[(NR_KEY-1-i)*PAIR_LEN+DATA_LEN +: KEY_LEN];
      pair_data[i] = i_lut[(NR_KEY-1-i)*PAIR_LEN +: DATA_LEN];
    end
  end

  always_comb begin
    o_data = '0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (pair_key[i] == i_key) begin
        o_data = o_data | pair_data[i];
      end
    end
  end

endmodule
